//--- vgaDisplay.f
vgaPkg.sv
vgaTiming.sv
vgaPattern.sv
vgaOutput.sv
vgaDisplay.sv
vgaDisplayTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the VGA display testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module vgaDisplayTb -f vgaDisplay.f

# a failing run still gets its output searched
simOut=$(./obj_dir/VvgaDisplayTb 2>&1 || true)
echo "$simOut"

if grep -q "TEST PASSED" <<< "$simOut"; then
	echo "simulation result: pass"
else
	echo "simulation result: fail"
	exit 1
fi

//--- vgaDisplayTb.sv
// directed testbench for the VGA test-pattern top level, run on a small raster with self-checks
`timescale 1ns/1ps
`default_nettype none

module vgaDisplayTb
	import vgaPkg::*;
;

	// --------------------
	// small raster
	localparam int hFrontTb = 5;
	localparam int hSyncTb  = 5;
	localparam int hBackTb  = 5;
	localparam int hDispTb  = 32;
	localparam int vFrontTb = 1;
	localparam int vSyncTb  = 1;
	localparam int vBackTb  = 1;
	localparam int vDispTb  = 5;
	localparam int lineLen  = hFrontTb + hSyncTb + hBackTb + hDispTb;
	localparam int frameLen = lineLen * (vFrontTb + vSyncTb + vBackTb + vDispTb);
	// visible window counted from the sync fall
	localparam int hVisStart = hSyncTb + hBackTb;
	localparam int vVisStart = vSyncTb + vBackTb;
	// mid-frame point for input changes inside the visible lines
	localparam int changeAt  = 200;
	localparam real clkPeriod = 40.0;
	// six frames per test plus some slack
	localparam int  testCount = 4;
	localparam real watchdogTime = (testCount * 6 * frameLen + 200) * clkPeriod;

	logic                  clk;
	logic                  rst_n;
	logic [modeWidth-1:0]  patternMode;
	logic [pixelWidth-1:0] userColor;
	logic                  hsync;
	logic                  vsync;
	logic                  videoEn;
	logic [colorWidth-1:0] vgaRed;
	logic [colorWidth-1:0] vgaBlue;
	logic [colorWidth-1:0] vgaGreen;

	// position tracked from the sync pins
	logic prevH;
	logic prevV;
	logic hFell;
	logic hRose;
	logic vFell;
	logic vRose;
	int   hPos;
	int   vLine;
	int   cycleNum;
	int   seed;

	vgaDisplay #(
		.hFront (hFrontTb),
		.hSync  (hSyncTb),
		.hBack  (hBackTb),
		.hDisp  (hDispTb),
		.vFront (vFrontTb),
		.vSync  (vSyncTb),
		.vBack  (vBackTb),
		.vDisp  (vDispTb)
	) UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.patternMode (patternMode),
		.userColor   (userColor),
		.hsync       (hsync),
		.vsync       (vsync),
		.videoEn     (videoEn),
		.vgaRed      (vgaRed),
		.vgaBlue     (vgaBlue),
		.vgaGreen    (vgaGreen)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial
	begin
		#(watchdogTime);
		failRun("Timeout: the display never finished the tests in the expected time");
	end

	// --------------------
	// checking helpers
	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			failRun($sformatf("Error: %s expected %0b actual %0b", name, expected, actual));
		end
	endtask

	task automatic checkPixel(input string name, input logic [pixelWidth-1:0] expected,
		input logic [pixelWidth-1:0] actual);
		if (actual !== expected)
		begin
			failRun($sformatf("Error: %s expected %03h actual %03h", name, expected, actual));
		end
	endtask

	task automatic checkCount(input string name, input logic [coordWidth-1:0] expected,
		input logic [coordWidth-1:0] actual);
		if (actual !== expected)
		begin
			failRun($sformatf("Error: %s expected %0d actual %0d", name, expected, actual));
		end
	endtask

	// colour on the pins in red / blue / green order from the top
	function automatic logic [pixelWidth-1:0] pinColor();
		return {vgaRed, vgaBlue, vgaGreen};
	endfunction

	// reference colour for one pixel
	function automatic logic [pixelWidth-1:0] patternColor(input logic [modeWidth-1:0] mode,
		input int x, input int y, input logic [pixelWidth-1:0] user);
		logic [2:0] bar;
		logic [3:0] ramp;
		bar  = 3'(x * 8 / hDispTb);
		ramp = 4'(x >> 3);
		case (mode)
			modeBars:
				return barColors[bar];
			modeChecker:
				return (x[3] ^ y[3]) ? 12'hFFF : 12'h000;
			modeSolid:
				return user;
			default:
				return {3{ramp}};
		endcase
	endfunction

	// --------------------
	// stepping and stimulus
	// one clock sampled at the falling edge before the tracked position moves on
	task automatic stepCycle();
		@(negedge clk);
		cycleNum = cycleNum + 1;
		hFell = prevH && !hsync;
		hRose = !prevH && hsync;
		vFell = prevV && !vsync;
		vRose = !prevV && vsync;
		if (hFell)
		begin
			hPos  = 0;
			vLine = vFell ? 0 : vLine + 1;
		end
		else
		begin
			hPos = hPos + 1;
		end
		prevH = hsync;
		prevV = vsync;
	endtask

	task automatic waitFrameStart();
		do
		begin
			stepCycle();
		end
		while (!vFell);
	endtask

	// change inputs in the middle of a frame
	task automatic applyInputs(input logic [modeWidth-1:0] mode,
		input logic [pixelWidth-1:0] user);
		waitFrameStart();
		repeat (changeAt) stepCycle();
		@(posedge clk);
		patternMode <= mode;
		userColor   <= user;
	endtask

	// checks one whole frame and may change inputs halfway
	task automatic checkFrame(input string name, input logic [modeWidth-1:0] mode,
		input logic [pixelWidth-1:0] user, input bit change,
		input logic [modeWidth-1:0] nextMode, input logic [pixelWidth-1:0] nextUser);
		int pixels;
		pixels = 0;
		waitFrameStart();
		for (int i = 0; i < frameLen; i++)
		begin
			if (i != 0)
			begin
				stepCycle();
			end
			if (videoEn)
			begin
				checkPixel(name, patternColor(mode, hPos - hVisStart, vLine - vVisStart, user),
					pinColor());
				pixels = pixels + 1;
			end
			if (change && (i == changeAt))
			begin
				@(posedge clk);
				patternMode <= nextMode;
				userColor   <= nextUser;
			end
		end
		checkCount({name, " pixel count"}, coordWidth'(hDispTb * vDispTb), coordWidth'(pixels));
	endtask

	// --------------------
	// tests
	task automatic testResetAndSync();
		int hFallAt;
		int vFallAt;
		int vPeriods;
		hFallAt  = -1;
		vFallAt  = -1;
		vPeriods = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		checkBit("reset hsync", 1'b1, hsync);
		checkBit("reset vsync", 1'b1, vsync);
		checkBit("reset videoEn", 1'b0, videoEn);
		checkPixel("reset colour", '0, pinColor());
		@(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < 2 * frameLen + lineLen; i++)
		begin
			stepCycle();
			if (hFell)
			begin
				if (hFallAt >= 0)
				begin
					checkCount("hsync period", coordWidth'(lineLen),
						coordWidth'(cycleNum - hFallAt));
				end
				hFallAt = cycleNum;
			end
			if (hRose && (hFallAt >= 0))
			begin
				checkCount("hsync low width", coordWidth'(hSyncTb),
					coordWidth'(cycleNum - hFallAt));
			end
			if (vFell)
			begin
				if (vFallAt >= 0)
				begin
					checkCount("vsync period", coordWidth'(frameLen),
						coordWidth'(cycleNum - vFallAt));
					vPeriods = vPeriods + 1;
				end
				vFallAt = cycleNum;
			end
			if (vRose && (vFallAt >= 0))
			begin
				checkCount("vsync low width", coordWidth'(vSyncTb * lineLen),
					coordWidth'(cycleNum - vFallAt));
			end
		end
		checkCount("vsync periods seen", coordWidth'(2), coordWidth'(vPeriods));
	endtask

	task automatic testVisibleArea();
		int   lineRun;
		int   litLines;
		logic prevEn;
		lineRun  = 0;
		litLines = 0;
		prevEn   = 1'b0;
		waitFrameStart();
		// one extra cycle closes the last visible line
		for (int i = 0; i <= frameLen; i++)
		begin
			if (i != 0)
			begin
				stepCycle();
			end
			if (videoEn && !prevEn)
			begin
				checkCount("enable start after hsync fall", coordWidth'(hVisStart),
					coordWidth'(hPos));
			end
			if (videoEn)
			begin
				lineRun = lineRun + 1;
			end
			else
			begin
				checkPixel("blanked colour", '0, pinColor());
				if (prevEn)
				begin
					checkCount("visible run length", coordWidth'(hDispTb), coordWidth'(lineRun));
					litLines = litLines + 1;
					lineRun  = 0;
				end
			end
			prevEn = videoEn;
		end
		checkCount("visible lines", coordWidth'(vDispTb), coordWidth'(litLines));
	endtask

	task automatic testBarsAndChecker();
		applyInputs(modeBars, '0);
		checkFrame("bars", modeBars, '0, 1'b0, modeBars, '0);
		applyInputs(modeChecker, '0);
		checkFrame("checker", modeChecker, '0, 1'b0, modeChecker, '0);
	endtask

	task automatic testSolidAndGradient();
		logic [pixelWidth-1:0] firstColor;
		logic [pixelWidth-1:0] secondColor;
		logic [pixelWidth-1:0] thirdColor;
		firstColor  = pixelWidth'($random(seed));
		secondColor = pixelWidth'($random(seed));
		thirdColor  = pixelWidth'($random(seed));
		// new colour must be visibly different
		if (secondColor == firstColor)
		begin
			secondColor = ~firstColor;
		end
		applyInputs(modeSolid, firstColor);
		checkFrame("solid old colour", modeSolid, firstColor, 1'b1, modeSolid, secondColor);
		checkFrame("solid new colour", modeSolid, secondColor, 1'b1, modeGradient, thirdColor);
		checkFrame("gradient", modeGradient, thirdColor, 1'b0, modeGradient, thirdColor);
	endtask

	// --------------------
	// main sequence
	initial
	begin
		rst_n       <= 1'b0;
		patternMode <= modeBars;
		userColor   <= '0;
		prevH    = 1'b1;
		prevV    = 1'b1;
		hFell    = 1'b0;
		hRose    = 1'b0;
		vFell    = 1'b0;
		vRose    = 1'b0;
		hPos     = 0;
		vLine    = 0;
		cycleNum = 0;
		seed     = 32'h7b9826be;
		testResetAndSync();
		testVisibleArea();
		testBarsAndChecker();
		testSolidAndGradient();
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vgaDisplay.sv
// top level of the VGA test-pattern display, wiring raster timing, pattern generator and output stage
`timescale 1ns/1ps
`default_nettype none

module vgaDisplay
	import vgaPkg::*;
#(
	// 640x480 at 60 Hz by default
	parameter int hFront = 16,
	parameter int hSync  = 96,
	parameter int hBack  = 48,
	parameter int hDisp  = 640,
	parameter int vFront = 10,
	parameter int vSync  = 2,
	parameter int vBack  = 33,
	parameter int vDisp  = 480
)
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [modeWidth-1:0]  patternMode,
	input  logic [pixelWidth-1:0] userColor,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  videoEn,
	output logic [colorWidth-1:0] vgaRed,
	output logic [colorWidth-1:0] vgaBlue,
	output logic [colorWidth-1:0] vgaGreen
);

	// raw timing, one cycle ahead of the pins
	logic                  hsyncRaw;
	logic                  vsyncRaw;
	logic                  activeRaw;
	// request side towards the pattern
	logic                  pixelRequest;
	logic                  frameStart;
	logic [coordWidth-1:0] xPos;
	logic [coordWidth-1:0] yPos;
	logic [pixelWidth-1:0] pixelData;

	// --------------------
	// raster timing
	vgaTiming #(
		.hFront (hFront),
		.hSync  (hSync),
		.hBack  (hBack),
		.hDisp  (hDisp),
		.vFront (vFront),
		.vSync  (vSync),
		.vBack  (vBack),
		.vDisp  (vDisp)
	) timing (
		.clk          (clk),
		.rst_n        (rst_n),
		.hsyncRaw     (hsyncRaw),
		.vsyncRaw     (vsyncRaw),
		.activeRaw    (activeRaw),
		.pixelRequest (pixelRequest),
		.frameStart   (frameStart),
		.xPos         (xPos),
		.yPos         (yPos)
	);

	// --------------------
	// pattern source
	vgaPattern #(
		.hDisp (hDisp)
	) pattern (
		.clk          (clk),
		.rst_n        (rst_n),
		.pixelRequest (pixelRequest),
		.frameStart   (frameStart),
		.xPos         (xPos),
		.yPos         (yPos),
		.patternMode  (patternMode),
		.userColor    (userColor),
		.pixelData    (pixelData)
	);

	// --------------------
	// pin registers
	vgaOutput out (
		.clk       (clk),
		.rst_n     (rst_n),
		.hsyncRaw  (hsyncRaw),
		.vsyncRaw  (vsyncRaw),
		.activeRaw (activeRaw),
		.pixelData (pixelData),
		.hsync     (hsync),
		.vsync     (vsync),
		.videoEn   (videoEn),
		.vgaRed    (vgaRed),
		.vgaBlue   (vgaBlue),
		.vgaGreen  (vgaGreen)
	);

endmodule

`default_nettype wire

//--- vgaOutput.sv
// VGA output registers under the display top, aligning syncs and enable and blanking the colour
`timescale 1ns/1ps
`default_nettype none

module vgaOutput
	import vgaPkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  hsyncRaw,
	input  logic                  vsyncRaw,
	input  logic                  activeRaw,
	input  logic [pixelWidth-1:0] pixelData,
	output logic                  hsync,
	output logic                  vsync,
	output logic                  videoEn,
	output logic [colorWidth-1:0] vgaRed,
	output logic [colorWidth-1:0] vgaBlue,
	output logic [colorWidth-1:0] vgaGreen
);

	// --------------------
	// sync and enable
	// syncs idle high out of reset
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hsync   <= 1'b1;
			vsync   <= 1'b1;
			videoEn <= 1'b0;
		end
		else
		begin
			hsync   <= hsyncRaw;
			vsync   <= vsyncRaw;
			videoEn <= activeRaw;
		end
	end

	// --------------------
	// colour
	// nibbles are red, blue, green from the top
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vgaRed   <= '0;
			vgaBlue  <= '0;
			vgaGreen <= '0;
		end
		else if (activeRaw)
		begin
			vgaRed   <= pixelData[11:8];
			vgaBlue  <= pixelData[7:4];
			vgaGreen <= pixelData[3:0];
		end
		else
		begin
			// blank in porches and sync
			vgaRed   <= '0;
			vgaBlue  <= '0;
			vgaGreen <= '0;
		end
	end

	// --------------------
	// checks
	// no colour ever leaks outside the visible area
	assert property (@(posedge clk) disable iff (!rst_n)
		!videoEn |-> ((vgaRed == '0) && (vgaBlue == '0) && (vgaGreen == '0)));

endmodule

`default_nettype wire

//--- vgaPattern.sv
// test-pattern generator answering each pixel request with a registered colour one cycle later
`timescale 1ns/1ps
`default_nettype none

module vgaPattern
	import vgaPkg::*;
#(
	parameter int hDisp = 640
)
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  pixelRequest,
	input  logic                  frameStart,
	input  logic [coordWidth-1:0] xPos,
	input  logic [coordWidth-1:0] yPos,
	input  logic [modeWidth-1:0]  patternMode,
	input  logic [pixelWidth-1:0] userColor,
	output logic [pixelWidth-1:0] pixelData
);

	// width of one bar, an eighth of the line
	localparam logic [coordWidth-1:0] barWidth = coordWidth'(hDisp / 8);

	logic [modeWidth-1:0]  modeLatched;
	logic [pixelWidth-1:0] colorLatched;
	logic [2:0]            barIndex;
	logic [coordWidth-1:0] barLimit;
	logic                  firstPixel;
	logic [2:0]            baseIndex;
	logic [coordWidth-1:0] baseLimit;
	logic [2:0]            curIndex;
	logic [coordWidth-1:0] curLimit;
	logic [pixelWidth-1:0] nextColor;

	// --------------------
	// frame-latched settings
	// sampled on the frame pulse, so a frame never mixes modes
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			modeLatched  <= modeBars;
			colorLatched <= '0;
		end
		else if (frameStart)
		begin
			modeLatched  <= patternMode;
			colorLatched <= userColor;
		end
	end

	// --------------------
	// bar tracking
	// first request of a line restarts at bar 0
	assign firstPixel = pixelRequest && (xPos == '0);

	always_comb
	begin
		baseIndex = firstPixel ? 3'd0 : barIndex;
		baseLimit = firstPixel ? barWidth : barLimit;
		curIndex  = baseIndex;
		curLimit  = baseLimit;
		// crossed into the next bar, last bar takes any remainder
		if ((xPos >= baseLimit) && (baseIndex != 3'd7))
		begin
			curIndex = baseIndex + 1'b1;
			curLimit = baseLimit + barWidth;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			barIndex <= '0;
			barLimit <= barWidth;
		end
		else if (pixelRequest)
		begin
			barIndex <= curIndex;
			barLimit <= curLimit;
		end
	end

	// --------------------
	// colour select
	always_comb
	begin
		case (modeLatched)
			modeBars:
				nextColor = barColors[curIndex];
			modeChecker:
				// 8-pixel squares
				nextColor = (xPos[3] ^ yPos[3]) ? 12'hFFF : 12'h000;
			modeSolid:
				nextColor = colorLatched;
			default:
				// gradient, same ramp on all three channels
				nextColor = {3{xPos[6:3]}};
		endcase
	end

	// held between requests
	always_ff @(posedge clk)
	begin
		if (pixelRequest)
		begin
			pixelData <= nextColor;
		end
	end

endmodule

`default_nettype wire

//--- vgaTiming.sv
// VGA raster counters, producing raw syncs, the visible flag and a one-cycle-early pixel request
`timescale 1ns/1ps
`default_nettype none

module vgaTiming
	import vgaPkg::*;
#(
	parameter int hFront = 16,
	parameter int hSync  = 96,
	parameter int hBack  = 48,
	parameter int hDisp  = 640,
	parameter int vFront = 10,
	parameter int vSync  = 2,
	parameter int vBack  = 33,
	parameter int vDisp  = 480
)
(
	input  logic                  clk,
	input  logic                  rst_n,
	output logic                  hsyncRaw,
	output logic                  vsyncRaw,
	output logic                  activeRaw,
	output logic                  pixelRequest,
	output logic                  frameStart,
	output logic [coordWidth-1:0] xPos,
	output logic [coordWidth-1:0] yPos
);

	// --------------------
	// raster geometry
	// line and frame lengths in counts
	localparam logic [coordWidth-1:0] hTotal = coordWidth'(hFront + hSync + hBack + hDisp);
	localparam logic [coordWidth-1:0] vTotal = coordWidth'(vFront + vSync + vBack + vDisp);
	// sync pulse sits at the start of each line / frame
	localparam logic [coordWidth-1:0] hSyncEnd = coordWidth'(hSync);
	localparam logic [coordWidth-1:0] vSyncEnd = coordWidth'(vSync);
	// visible windows after sync and back porch
	localparam logic [coordWidth-1:0] hStart = coordWidth'(hSync + hBack);
	localparam logic [coordWidth-1:0] hEnd   = coordWidth'(hSync + hBack + hDisp);
	localparam logic [coordWidth-1:0] vStart = coordWidth'(vSync + vBack);
	localparam logic [coordWidth-1:0] vEnd   = coordWidth'(vSync + vBack + vDisp);
	// request window leads the visible one by a single count
	localparam logic [coordWidth-1:0] reqStart = coordWidth'(hSync + hBack - 1);
	localparam logic [coordWidth-1:0] reqEnd   = coordWidth'(hSync + hBack + hDisp - 1);

	logic [coordWidth-1:0] hCount;
	logic [coordWidth-1:0] vCount;
	logic                  hWrap;
	logic                  vWrap;
	logic                  hVisible;
	logic                  vVisible;
	logic                  hRequest;

	// last count of a line and of a frame
	assign hWrap = (hCount == hTotal - 1'b1);
	assign vWrap = (vCount == vTotal - 1'b1);

	// --------------------
	// horizontal counter
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hCount <= '0;
		end
		else if (hWrap)
		begin
			hCount <= '0;
		end
		else
		begin
			hCount <= hCount + 1'b1;
		end
	end

	// --------------------
	// vertical counter
	// steps once per line, on the horizontal wrap
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vCount <= '0;
		end
		else if (hWrap)
		begin
			if (vWrap)
			begin
				vCount <= '0;
			end
			else
			begin
				vCount <= vCount + 1'b1;
			end
		end
	end

	// --------------------
	// decode
	// syncs active low during the first counts
	assign hsyncRaw = (hCount >= hSyncEnd);
	assign vsyncRaw = (vCount >= vSyncEnd);

	// visible area
	assign hVisible  = (hCount >= hStart) && (hCount < hEnd);
	assign vVisible  = (vCount >= vStart) && (vCount < vEnd);
	assign activeRaw = hVisible && vVisible;

	// request one clock ahead, same lines
	assign hRequest     = (hCount >= reqStart) && (hCount < reqEnd);
	assign pixelRequest = hRequest && vVisible;

	// positions of the requested pixel, zero when idle
	assign xPos = pixelRequest ? (hCount - reqStart) : '0;
	assign yPos = pixelRequest ? (vCount - vStart) : '0;

	// one cycle at the very end of the frame
	assign frameStart = hWrap && vWrap;

	// --------------------
	// checks
	// requested x never leaves the visible width
	assert property (@(posedge clk) disable iff (!rst_n)
		pixelRequest |-> (xPos < coordWidth'(hDisp)));

	// every visible pixel was requested the cycle before
	assert property (@(posedge clk) disable iff (!rst_n)
		activeRaw |-> $past(pixelRequest));

endmodule

`default_nettype wire

//--- vgaPkg.sv
// shared widths, pattern-mode codes and bar colours, imported by the VGA RTL and testbench
`default_nettype none

package vgaPkg;

	// --------------------
	// widths
	// counters and positions, totals up to 2047
	localparam int coordWidth = 11;
	// one colour channel
	localparam int colorWidth = 4;
	// pixel word, red / blue / green from the top
	localparam int pixelWidth = 12;
	// pattern-mode code
	localparam int modeWidth  = 2;

	// --------------------
	// pattern modes
	// eight vertical bars
	localparam logic [modeWidth-1:0] modeBars     = 2'd0;
	// 8x8 checkerboard
	localparam logic [modeWidth-1:0] modeChecker  = 2'd1;
	// user colour over the whole area
	localparam logic [modeWidth-1:0] modeSolid    = 2'd2;
	// grey ramp taken from x
	localparam logic [modeWidth-1:0] modeGradient = 2'd3;

	// --------------------
	// bar colours, left to right
	// nibble order is red, blue, green
	localparam logic [pixelWidth-1:0] barColors [8] = '{
		12'hFFF,	// white
		12'hF0F,	// yellow
		12'h0FF,	// cyan
		12'h00F,	// green
		12'hFF0,	// magenta
		12'hF00,	// red
		12'h0F0,	// blue
		12'h000		// black
	};

endpackage

`default_nettype wire
